// File: hdl/avr_core_consts.svh
`ifndef AVR_CORE_CONSTS_SVH
`define AVR_CORE_CONSTS_SVH

// Datapath widths
`define DATA_WIDTH      8
`define INSTR_WIDTH     16
`define PC_WIDTH        10   // 1K words of program ROM
`define ADDR_WIDTH      16   // 64KB data space
`define REG_ADDR_WIDTH  5    // 32 registers

// Data memory window reachable over the bus
`define MEM_START_ADDR  16'h0040
`define MEM_STOP_ADDR   16'h00BF

// Z pointer pair, r31:r30
`define REG_ZL          30
`define REG_ZH          31

`endif

// File: hdl/avr_core_pkg.sv
`include "avr_core_consts.svh"

package avr_core_pkg;

    // One stage per cycle, five cycles per instruction
    typedef enum logic [2:0] {
        STAGE_IF  = 3'd0,
        STAGE_ID  = 3'd1,
        STAGE_EX  = 3'd2,
        STAGE_MEM = 3'd3,
        STAGE_WB  = 3'd4
    } stage_t;

    typedef enum logic [2:0] {
        ALU_NONE = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_ADC  = 3'd2,
        ALU_SUB  = 3'd3,
        ALU_AND  = 3'd4,
        ALU_EOR  = 3'd5,
        ALU_OR   = 3'd6,
        ALU_NEG  = 3'd7
    } alu_op_t;

    typedef enum logic [2:0] {
        KIND_NOP = 3'd0,
        KIND_ALU = 3'd1,
        KIND_LDI = 3'd2,
        KIND_MOV = 3'd3,
        KIND_LD  = 3'd4,
        KIND_ST  = 3'd5
    } instr_kind_t;

    // Subset of SREG, no H and S
    typedef struct packed {
        logic c;
        logic z;
        logic n;
        logic v;
    } sreg_t;

    typedef struct packed {
        instr_kind_t                kind;
        alu_op_t                    alu_op;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`REG_ADDR_WIDTH-1:0] rr;
        logic [`DATA_WIDTH-1:0]     imm;
        logic                       writes_rd;
    } decoded_t;

    typedef struct packed {
        logic                   rd_en;
        logic                   wr_en;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] wdata;
    } mem_req_t;

endpackage

// File: hdl/instr_decoder.sv
`include "avr_core_consts.svh"

module instr_decoder (
    input  logic [`INSTR_WIDTH-1:0] instruction,
    output avr_core_pkg::decoded_t  decoded
);

    always_comb begin
        // Common field layout of the two-register format
        decoded.kind      = avr_core_pkg::KIND_NOP;
        decoded.alu_op    = avr_core_pkg::ALU_NONE;
        decoded.rd        = instruction[8:4];
        decoded.rr        = {instruction[9], instruction[3:0]};
        decoded.imm       = {instruction[11:8], instruction[3:0]};
        decoded.writes_rd = 1'b0;

        casez (instruction)
            16'b0000_11??_????_????: begin // ADD
                decoded.kind      = avr_core_pkg::KIND_ALU;
                decoded.alu_op    = avr_core_pkg::ALU_ADD;
                decoded.writes_rd = 1'b1;
            end
            16'b0001_11??_????_????: begin // ADC
                decoded.kind      = avr_core_pkg::KIND_ALU;
                decoded.alu_op    = avr_core_pkg::ALU_ADC;
                decoded.writes_rd = 1'b1;
            end
            16'b0001_10??_????_????: begin // SUB
                decoded.kind      = avr_core_pkg::KIND_ALU;
                decoded.alu_op    = avr_core_pkg::ALU_SUB;
                decoded.writes_rd = 1'b1;
            end
            16'b0010_00??_????_????: begin // AND
                decoded.kind      = avr_core_pkg::KIND_ALU;
                decoded.alu_op    = avr_core_pkg::ALU_AND;
                decoded.writes_rd = 1'b1;
            end
            16'b0010_01??_????_????: begin // EOR
                decoded.kind      = avr_core_pkg::KIND_ALU;
                decoded.alu_op    = avr_core_pkg::ALU_EOR;
                decoded.writes_rd = 1'b1;
            end
            16'b0010_10??_????_????: begin // OR
                decoded.kind      = avr_core_pkg::KIND_ALU;
                decoded.alu_op    = avr_core_pkg::ALU_OR;
                decoded.writes_rd = 1'b1;
            end
            16'b0010_11??_????_????: begin // MOV
                decoded.kind      = avr_core_pkg::KIND_MOV;
                decoded.writes_rd = 1'b1;
            end
            16'b1110_????_????_????: begin
                // LDI only reaches the upper half, r16..r31
                decoded.kind      = avr_core_pkg::KIND_LDI;
                decoded.rd        = {1'b1, instruction[7:4]};
                decoded.writes_rd = 1'b1;
            end
            16'b1001_010?_????_0001: begin // NEG
                decoded.kind      = avr_core_pkg::KIND_ALU;
                decoded.alu_op    = avr_core_pkg::ALU_NEG;
                decoded.writes_rd = 1'b1;
            end
            16'b1000_000?_????_0000: begin // LD Rd, Z
                decoded.kind      = avr_core_pkg::KIND_LD;
                decoded.writes_rd = 1'b1;
            end
            16'b1000_001?_????_0000: begin
                // ST Z, Rr keeps its source in the Rd field position
                decoded.kind = avr_core_pkg::KIND_ST;
                decoded.rr   = instruction[8:4];
            end
            default: ; // Everything else runs as NOP
        endcase
    end

endmodule

// File: hdl/control_unit.sv
`include "avr_core_consts.svh"

module control_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`INSTR_WIDTH-1:0]       instruction,
    output logic [`PC_WIDTH-1:0]          program_counter,
    output avr_core_pkg::stage_t          stage,
    output logic [`REG_ADDR_WIDTH-1:0]    rd_addr,
    output logic [`REG_ADDR_WIDTH-1:0]    rr_addr,
    input  logic [`DATA_WIDTH-1:0]        rd_data,
    input  logic [`DATA_WIDTH-1:0]        rr_data,
    input  logic [`DATA_WIDTH-1:0]        zl_data,
    input  logic [`DATA_WIDTH-1:0]        zh_data,
    output logic                          wr_en,
    output logic [`REG_ADDR_WIDTH-1:0]    wr_addr,
    output logic [`DATA_WIDTH-1:0]        wr_data,
    output avr_core_pkg::alu_op_t         alu_op,
    output logic [`DATA_WIDTH-1:0]        alu_a,
    output logic [`DATA_WIDTH-1:0]        alu_b,
    output avr_core_pkg::sreg_t           flags_in,
    input  logic [`DATA_WIDTH-1:0]        alu_result,
    input  avr_core_pkg::sreg_t           flags_out,
    output avr_core_pkg::mem_req_t        mem_req,
    input  logic [`DATA_WIDTH-1:0]        load_data
);

    avr_core_pkg::decoded_t     dec;
    avr_core_pkg::sreg_t        sreg;
    logic [`INSTR_WIDTH-1:0]    instr_buf;
    logic [`DATA_WIDTH-1:0]     rd_buf;     // Operand buffers from ID
    logic [`DATA_WIDTH-1:0]     rr_buf;
    logic [`DATA_WIDTH-1:0]     result_buf; // ALU result from EX
    logic [`DATA_WIDTH-1:0]     load_buf;   // Load data from MEM

    instr_decoder i_decoder (
        .instruction (instr_buf),
        .decoded     (dec)
    );

    // Stage sequencer, program counter and status register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stage           <= avr_core_pkg::STAGE_IF;
            program_counter <= '0;
            sreg            <= '0;
            instr_buf       <= '0; // Decodes as NOP
        end else begin
            case (stage)
                avr_core_pkg::STAGE_IF: begin
                    instr_buf <= instruction;
                    stage     <= avr_core_pkg::STAGE_ID;
                end
                avr_core_pkg::STAGE_ID:  stage <= avr_core_pkg::STAGE_EX;
                avr_core_pkg::STAGE_EX: begin
                    if (dec.kind == avr_core_pkg::KIND_ALU)
                        sreg <= flags_out; // Flags only move on ALU ops
                    stage <= avr_core_pkg::STAGE_MEM;
                end
                avr_core_pkg::STAGE_MEM: stage <= avr_core_pkg::STAGE_WB;
                default: begin
                    program_counter <= program_counter + 1'b1;
                    stage           <= avr_core_pkg::STAGE_IF;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (stage == avr_core_pkg::STAGE_ID) begin
            rd_buf <= rd_data;
            rr_buf <= rr_data;
        end
        if (stage == avr_core_pkg::STAGE_EX)
            result_buf <= alu_result;
        if (stage == avr_core_pkg::STAGE_MEM)
            load_buf <= load_data;
    end

    assign rd_addr  = dec.rd;
    assign rr_addr  = dec.rr;

    assign alu_op   = dec.alu_op;
    assign alu_a    = rd_buf;
    assign alu_b    = rr_buf;
    assign flags_in = sreg;

    // Write-back source by instruction kind
    always_comb begin
        case (dec.kind)
            avr_core_pkg::KIND_ALU: wr_data = result_buf;
            avr_core_pkg::KIND_LDI: wr_data = dec.imm;
            avr_core_pkg::KIND_MOV: wr_data = rr_buf;
            avr_core_pkg::KIND_LD:  wr_data = load_buf;
            default:                wr_data = '0;
        endcase
    end

    assign wr_en   = (stage == avr_core_pkg::STAGE_WB) && dec.writes_rd;
    assign wr_addr = dec.rd;

    // Z stays stable from ID to MEM since writes land only in WB
    always_comb begin
        mem_req       = '0;
        mem_req.addr  = {zh_data, zl_data};
        mem_req.wdata = rr_buf;
        if (stage == avr_core_pkg::STAGE_MEM) begin
            mem_req.rd_en = (dec.kind == avr_core_pkg::KIND_LD);
            mem_req.wr_en = (dec.kind == avr_core_pkg::KIND_ST);
        end
    end

endmodule

// File: hdl/register_file.sv
`include "avr_core_consts.svh"

module register_file (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`REG_ADDR_WIDTH-1:0] rd_addr,
    input  logic [`REG_ADDR_WIDTH-1:0] rr_addr,
    output logic [`DATA_WIDTH-1:0]     rd_data,
    output logic [`DATA_WIDTH-1:0]     rr_data,
    output logic [`DATA_WIDTH-1:0]     zl_data,
    output logic [`DATA_WIDTH-1:0]     zh_data,
    input  logic                       wr_en,
    input  logic [`REG_ADDR_WIDTH-1:0] wr_addr,
    input  logic [`DATA_WIDTH-1:0]     wr_data
);

    logic [`DATA_WIDTH-1:0] regs [2**`REG_ADDR_WIDTH];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**`REG_ADDR_WIDTH; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Asynchronous read ports
    assign rd_data = regs[rd_addr];
    assign rr_data = regs[rr_addr];

    assign zl_data = regs[`REG_ZL]; // Pointer for LD/ST Z
    assign zh_data = regs[`REG_ZH];

endmodule

// File: hdl/alu.sv
`include "avr_core_consts.svh"

module alu (
    input  avr_core_pkg::alu_op_t  op,
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    input  avr_core_pkg::sreg_t    flags_in,
    output logic [`DATA_WIDTH-1:0] result,
    output avr_core_pkg::sreg_t    flags_out
);

    logic [`DATA_WIDTH:0] wide; // Result with carry or borrow bit

    always_comb begin
        wide      = '0;
        flags_out = flags_in;

        case (op)
            avr_core_pkg::ALU_ADD: begin
                wide        = {1'b0, a} + {1'b0, b};
                flags_out.c = wide[`DATA_WIDTH];
                flags_out.v = (a[`DATA_WIDTH-1] == b[`DATA_WIDTH-1]) &&
                              (wide[`DATA_WIDTH-1] != a[`DATA_WIDTH-1]);
            end
            avr_core_pkg::ALU_ADC: begin
                wide        = {1'b0, a} + {1'b0, b} + {{`DATA_WIDTH{1'b0}}, flags_in.c};
                flags_out.c = wide[`DATA_WIDTH];
                flags_out.v = (a[`DATA_WIDTH-1] == b[`DATA_WIDTH-1]) &&
                              (wide[`DATA_WIDTH-1] != a[`DATA_WIDTH-1]);
            end
            avr_core_pkg::ALU_SUB: begin
                wide        = {1'b0, a} - {1'b0, b};
                flags_out.c = wide[`DATA_WIDTH]; // Borrow, a < b unsigned
                flags_out.v = (a[`DATA_WIDTH-1] != b[`DATA_WIDTH-1]) &&
                              (wide[`DATA_WIDTH-1] != a[`DATA_WIDTH-1]);
            end
            avr_core_pkg::ALU_AND: begin
                wide        = {1'b0, a & b};
                flags_out.v = 1'b0;
            end
            avr_core_pkg::ALU_EOR: begin
                wide        = {1'b0, a ^ b};
                flags_out.v = 1'b0;
            end
            avr_core_pkg::ALU_OR: begin
                wide        = {1'b0, a | b};
                flags_out.v = 1'b0;
            end
            avr_core_pkg::ALU_NEG: begin
                // Two's complement of Rd, b is not used
                wide        = {1'b0, -a};
                flags_out.c = (wide[`DATA_WIDTH-1:0] != '0);
                flags_out.v = (wide[`DATA_WIDTH-1:0] == {1'b1, {(`DATA_WIDTH-1){1'b0}}});
            end
            default: ; // ALU_NONE keeps the flags
        endcase

        if (op != avr_core_pkg::ALU_NONE) begin
            flags_out.z = (wide[`DATA_WIDTH-1:0] == '0);
            flags_out.n = wide[`DATA_WIDTH-1];
        end
    end

    assign result = wide[`DATA_WIDTH-1:0];

endmodule

// File: hdl/data_bus_unit.sv
`include "avr_core_consts.svh"

module data_bus_unit (
    input  avr_core_pkg::mem_req_t  mem_req,
    output logic [`DATA_WIDTH-1:0]  load_data,
    output logic [`ADDR_WIDTH-1:0]  bus_addr,
    output logic [`DATA_WIDTH-1:0]  bus_wdata,
    input  logic [`DATA_WIDTH-1:0]  bus_rdata,
    output logic                    mem_we,
    output logic                    mem_oe
);

    logic in_window;

    // Only this address range is backed by memory
    assign in_window = (mem_req.addr >= `MEM_START_ADDR) &&
                       (mem_req.addr <= `MEM_STOP_ADDR);

    assign bus_addr  = mem_req.addr;
    assign bus_wdata = mem_req.wdata;

    assign mem_we = mem_req.wr_en && in_window; // Out-of-window stores dropped
    assign mem_oe = mem_req.rd_en && in_window;

    // Out-of-window loads read as zero
    assign load_data = mem_oe ? bus_rdata : '0;

endmodule

// File: hdl/avr_core.sv
`include "avr_core_consts.svh"

module avr_core (
    input  logic                    clk,
    input  logic                    reset,
    output logic [`PC_WIDTH-1:0]    program_counter,
    input  logic [`INSTR_WIDTH-1:0] instruction,
    output logic [`ADDR_WIDTH-1:0]  bus_addr,
    output logic [`DATA_WIDTH-1:0]  bus_wdata,
    input  logic [`DATA_WIDTH-1:0]  bus_rdata,
    output logic                    mem_we,
    output logic                    mem_oe
);

    avr_core_pkg::stage_t         stage;
    logic [`REG_ADDR_WIDTH-1:0]   rd_addr;
    logic [`REG_ADDR_WIDTH-1:0]   rr_addr;
    logic [`DATA_WIDTH-1:0]       rd_data;
    logic [`DATA_WIDTH-1:0]       rr_data;
    logic [`DATA_WIDTH-1:0]       zl_data;
    logic [`DATA_WIDTH-1:0]       zh_data;
    logic                         wr_en;
    logic [`REG_ADDR_WIDTH-1:0]   wr_addr;
    logic [`DATA_WIDTH-1:0]       wr_data;
    avr_core_pkg::alu_op_t        alu_op;
    logic [`DATA_WIDTH-1:0]       alu_a;
    logic [`DATA_WIDTH-1:0]       alu_b;
    avr_core_pkg::sreg_t          flags_in;
    logic [`DATA_WIDTH-1:0]       alu_result;
    avr_core_pkg::sreg_t          flags_out;
    avr_core_pkg::mem_req_t       mem_req;
    logic [`DATA_WIDTH-1:0]       load_data;

    control_unit i_control (
        .clk             (clk),
        .reset           (reset),
        .instruction     (instruction),
        .program_counter (program_counter),
        .stage           (stage),
        .rd_addr         (rd_addr),
        .rr_addr         (rr_addr),
        .rd_data         (rd_data),
        .rr_data         (rr_data),
        .zl_data         (zl_data),
        .zh_data         (zh_data),
        .wr_en           (wr_en),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .alu_op          (alu_op),
        .alu_a           (alu_a),
        .alu_b           (alu_b),
        .flags_in        (flags_in),
        .alu_result      (alu_result),
        .flags_out       (flags_out),
        .mem_req         (mem_req),
        .load_data       (load_data)
    );

    register_file i_regs (
        .clk     (clk),
        .reset   (reset),
        .rd_addr (rd_addr),
        .rr_addr (rr_addr),
        .rd_data (rd_data),
        .rr_data (rr_data),
        .zl_data (zl_data),
        .zh_data (zh_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    alu i_alu (
        .op        (alu_op),
        .a         (alu_a),
        .b         (alu_b),
        .flags_in  (flags_in),
        .result    (alu_result),
        .flags_out (flags_out)
    );

    data_bus_unit i_bus (
        .mem_req   (mem_req),
        .load_data (load_data),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .mem_we    (mem_we),
        .mem_oe    (mem_oe)
    );

endmodule

// File: test/avr_core_asserts.sv
`include "avr_core_consts.svh"

module avr_core_asserts (
    input logic                   clk,
    input logic                   reset,
    input logic                   mem_we,
    input logic                   mem_oe,
    input logic [`ADDR_WIDTH-1:0] bus_addr,
    input avr_core_pkg::stage_t   stage
);

    // Read and write strobes are exclusive
    strobe_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_we && mem_oe))
        else $error("mem_we and mem_oe are high in the same cycle");

    strobe_in_window: assert property (@(posedge clk) disable iff (reset)
        (mem_we || mem_oe) |->
            (bus_addr >= `MEM_START_ADDR && bus_addr <= `MEM_STOP_ADDR))
        else $error("memory strobe with bus_addr 0x%04h outside the window", bus_addr);

    strobe_in_mem_stage: assert property (@(posedge clk) disable iff (reset)
        (mem_we || mem_oe) |-> (stage == avr_core_pkg::STAGE_MEM))
        else $error("memory strobe outside STAGE_MEM");

endmodule

bind avr_core avr_core_asserts i_asserts (
    .clk      (clk),
    .reset    (reset),
    .mem_we   (mem_we),
    .mem_oe   (mem_oe),
    .bus_addr (bus_addr),
    .stage    (stage)
);

// File: test/tb_avr_core.sv
`include "avr_core_consts.svh"

module tb_avr_core;

    localparam int GOLDEN_DEPTH = 128;
    localparam int ROM_DEPTH    = 2**`PC_WIDTH;

    logic                    clk;
    logic                    reset;
    logic [`PC_WIDTH-1:0]    pc;
    logic [`INSTR_WIDTH-1:0] instruction;
    logic [`ADDR_WIDTH-1:0]  bus_addr;
    logic [`DATA_WIDTH-1:0]  bus_wdata;
    logic [`DATA_WIDTH-1:0]  bus_rdata;
    logic                    mem_we;
    logic                    mem_oe;

    logic [23:0]             golden [GOLDEN_DEPTH]; // Program words followed by store records
    logic [`INSTR_WIDTH-1:0] rom    [ROM_DEPTH];
    logic [`DATA_WIDTH-1:0]  dmem   [256];

    int   prog_len;
    int   num_stores;
    int   cycle_limit;
    int   cycle_count = 0;
    int   phase       = 0; // Cycle within the current instruction
    int   expected_pc = 0;
    int   store_count = 0;
    logic running;

    avr_core i_dut (
        .clk             (clk),
        .reset           (reset),
        .program_counter (pc),
        .instruction     (instruction),
        .bus_addr        (bus_addr),
        .bus_wdata       (bus_wdata),
        .bus_rdata       (bus_rdata),
        .mem_we          (mem_we),
        .mem_oe          (mem_oe)
    );

    // Asynchronous ROM and data memory reads
    assign instruction = rom[pc];
    assign bus_rdata   = dmem[bus_addr[7:0]];

    always @(posedge clk) begin
        if (mem_we)
            dmem[bus_addr[7:0]] <= bus_wdata;
    end

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_failed();
        $display("sim failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic compare_value(input string test_name, input int expected,
                                 input int actual);
        assert (actual == expected) else begin
            $display("error %s: expected 0x%0h, actual 0x%0h",
                     test_name, expected, actual);
            stop_failed();
        end
    endtask

    // Each write strobe must match the next golden record
    task automatic check_store();
        logic [23:0] record;
        assert (store_count < num_stores) else begin
            $display("store to 0x%04h found after the last golden record", bus_addr);
            stop_failed();
        end
        record = golden[prog_len + 2 + store_count];
        compare_value($sformatf("store %0d address", store_count),
                      int'(record[23:8]), int'(bus_addr));
        compare_value($sformatf("store %0d data", store_count),
                      int'(record[7:0]), int'(bus_wdata));
        store_count = store_count + 1;
    endtask

    // Sample mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (reset) begin
            compare_value("reset pc", 0, int'(pc));
            compare_value("reset mem_we", 0, int'(mem_we));
            compare_value("reset mem_oe", 0, int'(mem_oe));
        end else if (running) begin
            compare_value($sformatf("pc at cycle %0d", cycle_count), expected_pc, int'(pc));
            if (mem_we)
                check_store();
            phase = phase + 1;
            if (phase == 5) begin // PC steps once per instruction
                phase       = 0;
                expected_pc = expected_pc + 1;
            end
            cycle_count = cycle_count + 1;
        end
    end

    initial begin
        reset   = 1'b1;
        running = 1'b0;
        void'($urandom(60470));
        for (int i = 0; i < 256; i++)
            dmem[i] <= 8'(i) ^ 8'h5A; // Nonzero outside the window too
        for (int i = 0; i < ROM_DEPTH; i++)
            rom[i] = '0; // NOP beyond the program
        $readmemh("test/avr_core_golden.txt", golden);
        prog_len   = int'(golden[0]);
        num_stores = int'(golden[prog_len + 1]);
        assert (prog_len > 0 && prog_len + num_stores + 2 <= GOLDEN_DEPTH) else begin
            $display("golden file is missing or has a bad length field");
            stop_failed();
        end
        for (int i = 0; i < prog_len; i++)
            rom[i] = golden[i + 1][`INSTR_WIDTH-1:0];
        cycle_limit = 5 * prog_len + 20;

        repeat (5) @(posedge clk);
        #2;
        reset   = 1'b0;
        running = 1'b1;

        // One extra NOP so the final pc step gets checked too
        while (expected_pc <= prog_len && cycle_count < cycle_limit)
            @(posedge clk);

        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles before the program finished", cycle_limit);
            stop_failed();
        end else begin
            compare_value("store count", num_stores, store_count);
            $display("sim passed");
            $finish;
        end
    end

endmodule

// File: test/avr_core_golden.txt
// Word 0 is the program length, then one 16-bit program word per entry.
// Next the store count, then one store record per entry as {addr[15:0], data[7:0]}.
0033
E0F0 E4E0            // Z = 0x0040
EF00 E210 0F01 8300  // ADD F0+20 and store 10 at 0x40
E021 1F21 E4E1 8320  // ADC 01+20+c and store 22 at 0x41
E035 E047 E150 1B34  // SUB 05-07 sets borrow
1F51                 // ADC 10+20+c
E4E2 8330 E4E3 8350  // Store FE at 0x42 and 31 at 0x43
EC6C EA7A 2367       // AND CC with AA
E4E4 8360            // Store 88 at 0x44
EC8C 2787 E4E5 8380  // EOR CC with AA gives 66 at 0x45
E09F 2B97 E4E6 8390  // OR 0F with AA gives AF at 0x46
E0A1 95A1 E4E7 83A0  // NEG 01 gives FF at 0x47
2E26 E4E8 8220       // MOV r2 from r22 then store at 0x48
E4E0 8030 E5E0 8230  // LD back from 0x40 and store at 0x50
ECE0 8300            // Store to 0x00C0 is dropped
2E40 8040            // r4 = 10 then LD from 0x00C0 reads zero
E5E1 8240            // Store r4 at 0x51
0000 FFFF            // NOP and an unknown code
000B
004010 004122 0042FE 004331
004488 004566 0046AF 0047FF
004888 005010 005100

// File: avr_core.f
+incdir+hdl
hdl/avr_core_pkg.sv
hdl/instr_decoder.sv
hdl/control_unit.sv
hdl/register_file.sv
hdl/alu.sv
hdl/data_bus_unit.sv
hdl/avr_core.sv
test/avr_core_asserts.sv
test/tb_avr_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the avr_core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_avr_core -f avr_core.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_avr_core 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
